// File: rtl/texSampler_cfg.svh
`ifndef TEX_SAMPLER_CFG_SVH
`define TEX_SAMPLER_CFG_SVH

// Texel storage and upload widths
`define TEXEL_WIDTH       16
`define STREAM_WIDTH      32
`define TEX_ADDR_WIDTH    12

// Coordinates are unsigned Q8.8 in texel units
`define COORD_INT_WIDTH   8
`define COORD_FRAC_WIDTH  8
`define LOG2_MAX          6

// Register map of the AXI4-Lite slave
`define REG_ADDR_WIDTH    4
`define REG_TEX_SIZE      4'h0
`define REG_WRAP_MODE     4'h4
`define RESET_LOG2        6

`endif

// File: rtl/texSamplerPkg.sv
`include "texSampler_cfg.svh"

package texSamplerPkg;

    // One texel and a row-major index into the whole texture
    typedef logic [`TEXEL_WIDTH-1:0]      texel_t;
    typedef logic [`TEX_ADDR_WIDTH-1:0]   texAddr_t;

    // Integer and fraction parts of one coordinate axis
    typedef logic [`COORD_INT_WIDTH-1:0]  coordInt_t;
    typedef logic [`COORD_FRAC_WIDTH-1:0] coordFrac_t;

    // Log2 of a texture dimension up to 6
    typedef logic [2:0]                   sizeLog2_t;

    typedef logic [`STREAM_WIDTH-1:0]     streamBeat_t;
    typedef logic [31:0]                  regData_t;
    typedef logic [`REG_ADDR_WIDTH-1:0]   regAddr_t;

    typedef struct packed {
        coordInt_t  sInt;
        coordFrac_t sFrac;
        coordInt_t  tInt;
        coordFrac_t tFrac;
    } texCoord_t;

    typedef struct packed {
        sizeLog2_t widthLog2;
        sizeLog2_t heightLog2;
        logic      clampS;
        logic      clampT;
    } texConfig_t;

    // Index 01 is the s+1 neighbour, 10 the t+1 neighbour
    typedef struct packed {
        texAddr_t addr00;
        texAddr_t addr01;
        texAddr_t addr10;
        texAddr_t addr11;
    } texelQuadAddr_t;

    typedef struct packed {
        texel_t texel00;
        texel_t texel01;
        texel_t texel10;
        texel_t texel11;
    } texelQuad_t;

    typedef struct packed {
        coordFrac_t fracS;
        coordFrac_t fracT;
    } texFrac_t;

    typedef enum logic {
        IDLE,
        RESPOND
    } regWriteState_t;

endpackage

// File: rtl/texSamplerRegs.sv
`timescale 1ns/1ns
`include "texSampler_cfg.svh"

module texSamplerRegs
(
    input  logic                      aclk,
    input  logic                      resetn,

    input  texSamplerPkg::regAddr_t   awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  texSamplerPkg::regData_t   wdata,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,

    input  texSamplerPkg::regAddr_t   araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output texSamplerPkg::regData_t   rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready,

    output texSamplerPkg::texConfig_t texConfig
);
    import texSamplerPkg::*;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    regWriteState_t writeState;
    logic           writeTaken;
    logic           writeKnown;

    // Larger sizes do not fit the texel memory, so they are cut to the maximum
    function automatic sizeLog2_t saturateLog2(input sizeLog2_t value);
        return (value > sizeLog2_t'(`LOG2_MAX)) ? sizeLog2_t'(`LOG2_MAX) : value;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Write channel
    ////////////////////////////////////////////////////////////////////////////

    // Address and data are only taken as a pair, and never while a response waits
    assign writeTaken = (writeState == IDLE) && awvalid && wvalid;
    assign awready    = writeTaken;
    assign wready     = writeTaken;
    assign bvalid     = (writeState == RESPOND);
    assign writeKnown = (awaddr == `REG_TEX_SIZE) || (awaddr == `REG_WRAP_MODE);

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            writeState           <= IDLE;
            texConfig.widthLog2  <= sizeLog2_t'(`RESET_LOG2);
            texConfig.heightLog2 <= sizeLog2_t'(`RESET_LOG2);
            texConfig.clampS     <= 1'b0;
            texConfig.clampT     <= 1'b0;
        end
        else
        begin
            case (writeState)
                IDLE:
                begin
                    if (writeTaken)
                    begin
                        if (awaddr == `REG_TEX_SIZE)
                        begin
                            texConfig.widthLog2  <= saturateLog2(wdata[2:0]);
                            texConfig.heightLog2 <= saturateLog2(wdata[6:4]);
                        end
                        else if (awaddr == `REG_WRAP_MODE)
                        begin
                            texConfig.clampS <= wdata[0];
                            texConfig.clampT <= wdata[1];
                        end
                        writeState <= RESPOND;
                    end
                end
                RESPOND:
                begin
                    // Hold the response until the host takes it
                    if (bready)
                        writeState <= IDLE;
                end
                default:
                    writeState <= IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk)
    begin
        if (writeTaken)
            bresp <= writeKnown ? RESP_OKAY : RESP_SLVERR;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read channel
    ////////////////////////////////////////////////////////////////////////////

    // A new read address is accepted only once the previous data has left
    assign arready = !rvalid;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
            rvalid <= 1'b0;
        else if (arvalid && arready)
            rvalid <= 1'b1;
        else if (rready)
            rvalid <= 1'b0;
    end

    always_ff @(posedge aclk)
    begin
        if (arvalid && arready)
        begin
            rdata <= '0;
            rresp <= RESP_OKAY;
            case (araddr)
                `REG_TEX_SIZE:
                begin
                    rdata[2:0] <= texConfig.widthLog2;
                    rdata[6:4] <= texConfig.heightLog2;
                end
                `REG_WRAP_MODE:
                    rdata[1:0] <= {texConfig.clampT, texConfig.clampS};
                default:
                    rresp <= RESP_SLVERR;
            endcase
        end
    end

endmodule

// File: rtl/texelAddressGen.sv
`timescale 1ns/1ns

module texelAddressGen
(
    input  logic                          aclk,
    input  texSamplerPkg::texConfig_t     texConfig,
    input  texSamplerPkg::texCoord_t      coord,
    output texSamplerPkg::texelQuadAddr_t quadAddr,
    output texSamplerPkg::texFrac_t       frac
);
    import texSamplerPkg::*;

    coordInt_t widthMask;
    coordInt_t heightMask;
    coordInt_t s0;
    coordInt_t s1;
    coordInt_t t0;
    coordInt_t t1;
    texFrac_t  fracStage;

    // Row-major index with the row shifted by the width log2
    function automatic texAddr_t rowMajor(input coordInt_t s, input coordInt_t t,
                                          input sizeLog2_t widthLog2);
        return (texAddr_t'(t) << widthLog2) | texAddr_t'(s);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Wrap and clamp
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        // Sizes are powers of two, so modulo is a mask
        widthMask  = ~({$bits(coordInt_t){1'b1}} << texConfig.widthLog2);
        heightMask = ~({$bits(coordInt_t){1'b1}} << texConfig.heightLog2);
        s0 = coord.sInt & widthMask;
        t0 = coord.tInt & heightMask;

        // In clamp mode the neighbour stays on the last column
        if (texConfig.clampS)
            s1 = (s0 == widthMask) ? s0 : s0 + 1'b1;
        else
            s1 = (s0 + 1'b1) & widthMask;

        // The same rule per row, against the height
        if (texConfig.clampT)
            t1 = (t0 == heightMask) ? t0 : t0 + 1'b1;
        else
            t1 = (t0 + 1'b1) & heightMask;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk)
    begin
        quadAddr.addr00 <= rowMajor(s0, t0, texConfig.widthLog2);
        quadAddr.addr01 <= rowMajor(s1, t0, texConfig.widthLog2);
        quadAddr.addr10 <= rowMajor(s0, t1, texConfig.widthLog2);
        quadAddr.addr11 <= rowMajor(s1, t1, texConfig.widthLog2);

        // The fractions get one more stage to line up with the texel read
        fracStage.fracS <= coord.sFrac;
        fracStage.fracT <= coord.tFrac;
        frac            <= fracStage;
    end

endmodule

// File: rtl/texelBankRam.sv
`timescale 1ns/1ns
`include "texSampler_cfg.svh"

module texelBankRam
(
    input  logic                        aclk,
    input  logic                        write,
    input  logic [`TEX_ADDR_WIDTH-2:0]  addrA,
    input  texSamplerPkg::texel_t       dataIn,
    output texSamplerPkg::texel_t       dataOutA,
    input  logic [`TEX_ADDR_WIDTH-2:0]  addrB,
    output texSamplerPkg::texel_t       dataOutB
);
    import texSamplerPkg::*;

    // Each bank holds every second column, so half the texture
    localparam int DEPTH = 2 ** (`TEX_ADDR_WIDTH - 1);

    texel_t mem [DEPTH];

    // Port A is shared between the upload and the t+1 row reads
    always_ff @(posedge aclk)
    begin
        if (write)
            mem[addrA] <= dataIn;
        else
            dataOutA <= mem[addrA];
    end

    always_ff @(posedge aclk)
    begin
        dataOutB <= mem[addrB];
    end

endmodule

// File: rtl/texelQuadBuffer.sv
`timescale 1ns/1ns
`include "texSampler_cfg.svh"

module texelQuadBuffer
(
    input  logic                          aclk,
    input  logic                          resetn,

    input  texSamplerPkg::texelQuadAddr_t quadAddr,
    output texSamplerPkg::texelQuad_t     quad,

    input  logic                          tvalid,
    output logic                          tready,
    input  logic                          tlast,
    input  texSamplerPkg::streamBeat_t    tdata
);
    import texSamplerPkg::*;

    logic [`TEX_ADDR_WIDTH-2:0] writePtr;
    logic [`TEX_ADDR_WIDTH-2:0] evenAddrRow0;
    logic [`TEX_ADDR_WIDTH-2:0] oddAddrRow0;
    logic [`TEX_ADDR_WIDTH-2:0] evenAddrRow1;
    logic [`TEX_ADDR_WIDTH-2:0] oddAddrRow1;

    texel_t evenDataRow0;
    texel_t oddDataRow0;
    texel_t evenDataRow1;
    texel_t oddDataRow1;

    // Parity of each quad address, kept for the cycle the banks answer
    logic odd00;
    logic odd01;
    logic odd10;
    logic odd11;

    ////////////////////////////////////////////////////////////////////////////
    // Upload stream
    ////////////////////////////////////////////////////////////////////////////

    // The stream is never stalled, every valid beat is written
    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            writePtr <= '0;
            tready   <= 1'b1;
        end
        else if (tvalid)
        begin
            if (tlast)
                writePtr <= '0;
            else
                writePtr <= writePtr + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read address steering
    ////////////////////////////////////////////////////////////////////////////

    // Neighbours in s sit in opposite banks, so the parity of the base
    // texel picks which bank serves which neighbour
    always_comb
    begin
        if (quadAddr.addr00[0])
        begin
            evenAddrRow0 = quadAddr.addr01[`TEX_ADDR_WIDTH-1:1];
            oddAddrRow0  = quadAddr.addr00[`TEX_ADDR_WIDTH-1:1];
        end
        else
        begin
            evenAddrRow0 = quadAddr.addr00[`TEX_ADDR_WIDTH-1:1];
            oddAddrRow0  = quadAddr.addr01[`TEX_ADDR_WIDTH-1:1];
        end

        if (quadAddr.addr10[0])
        begin
            evenAddrRow1 = quadAddr.addr11[`TEX_ADDR_WIDTH-1:1];
            oddAddrRow1  = quadAddr.addr10[`TEX_ADDR_WIDTH-1:1];
        end
        else
        begin
            evenAddrRow1 = quadAddr.addr10[`TEX_ADDR_WIDTH-1:1];
            oddAddrRow1  = quadAddr.addr11[`TEX_ADDR_WIDTH-1:1];
        end
    end

    // Beat n carries texel 2n in its low half and 2n+1 in its high half
    texelBankRam evenBank_i
    (
        .aclk(aclk),
        .write(tvalid),
        .addrA(tvalid ? writePtr : evenAddrRow1),
        .dataIn(tdata[`TEXEL_WIDTH-1:0]),
        .dataOutA(evenDataRow1),
        .addrB(evenAddrRow0),
        .dataOutB(evenDataRow0)
    );

    texelBankRam oddBank_i
    (
        .aclk(aclk),
        .write(tvalid),
        .addrA(tvalid ? writePtr : oddAddrRow1),
        .dataIn(tdata[`STREAM_WIDTH-1 -: `TEXEL_WIDTH]),
        .dataOutA(oddDataRow1),
        .addrB(oddAddrRow0),
        .dataOutB(oddDataRow0)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Data return
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk)
    begin
        odd00 <= quadAddr.addr00[0];
        odd01 <= quadAddr.addr01[0];
        odd10 <= quadAddr.addr10[0];
        odd11 <= quadAddr.addr11[0];
    end

    // When both neighbours share a parity they are the same texel, so
    // selecting by each texel's own parity still lands on the right bank
    always_comb
    begin
        quad.texel00 = odd00 ? oddDataRow0 : evenDataRow0;
        quad.texel01 = odd01 ? oddDataRow0 : evenDataRow0;
        quad.texel10 = odd10 ? oddDataRow1 : evenDataRow1;
        quad.texel11 = odd11 ? oddDataRow1 : evenDataRow1;
    end

endmodule

// File: rtl/texSampler.sv
`timescale 1ns/1ns

module texSampler
(
    input  logic                      aclk,
    input  logic                      resetn,

    input  texSamplerPkg::regAddr_t   awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  texSamplerPkg::regData_t   wdata,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  texSamplerPkg::regAddr_t   araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output texSamplerPkg::regData_t   rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready,

    input  logic                      texStreamTvalid,
    output logic                      texStreamTready,
    input  logic                      texStreamTlast,
    input  texSamplerPkg::streamBeat_t texStreamTdata,

    input  logic                      sampleValid,
    input  texSamplerPkg::texCoord_t  coord,
    output logic                      quadValid,
    output texSamplerPkg::texelQuad_t quad,
    output texSamplerPkg::texFrac_t   frac
);
    import texSamplerPkg::*;

    texConfig_t     texConfig;
    texelQuadAddr_t quadAddr;

    // Valid flag travels beside the address stage and the bank read stage
    logic [1:0] validPipe;

    texSamplerRegs regs_i
    (
        .aclk(aclk),
        .resetn(resetn),
        .awaddr(awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata(wdata),
        .wvalid(wvalid),
        .wready(wready),
        .bresp(bresp),
        .bvalid(bvalid),
        .bready(bready),
        .araddr(araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata(rdata),
        .rresp(rresp),
        .rvalid(rvalid),
        .rready(rready),
        .texConfig(texConfig)
    );

    texelAddressGen addrGen_i
    (
        .aclk(aclk),
        .texConfig(texConfig),
        .coord(coord),
        .quadAddr(quadAddr),
        .frac(frac)
    );

    texelQuadBuffer quadBuffer_i
    (
        .aclk(aclk),
        .resetn(resetn),
        .quadAddr(quadAddr),
        .quad(quad),
        .tvalid(texStreamTvalid),
        .tready(texStreamTready),
        .tlast(texStreamTlast),
        .tdata(texStreamTdata)
    );

    always_ff @(posedge aclk)
    begin
        if (!resetn)
            validPipe <= 2'b00;
        else
            validPipe <= {validPipe[0], sampleValid};
    end

    assign quadValid = validPipe[1];

endmodule

// File: tests/texSamplerTb.sv
`timescale 1ns/1ns
`include "texSampler_cfg.svh"

module texSamplerTb;
    import texSamplerPkg::*;

    // Upload of 128 beats, about 20 register accesses and roughly 600 sample
    // cycles come to under a thousand cycles
    localparam int CYCLE_LIMIT = 2000;
    localparam int TEX_LOG2    = 4;
    localparam int BEAT_COUNT  = (1 << (2 * TEX_LOG2)) / 2;

    // One expected result as queued in request order
    typedef struct packed {
        texelQuad_t quad;
        texFrac_t   frac;
    } sampleExpect_t;

    logic        aclk;
    logic        resetn;
    regAddr_t    awaddr;
    logic        awvalid;
    logic        awready;
    regData_t    wdata;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    regAddr_t    araddr;
    logic        arvalid;
    logic        arready;
    regData_t    rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        texStreamTvalid;
    logic        texStreamTready;
    logic        texStreamTlast;
    streamBeat_t texStreamTdata;
    logic        sampleValid;
    texCoord_t   coord;
    logic        quadValid;
    texelQuad_t  quad;
    texFrac_t    frac;

    integer        seed = 32'hf09;
    int            cycleCount = 0;
    int            requestCount = 0;
    int            resultCount = 0;
    texel_t        texModel [4096];
    int            modelWidthLog2;
    int            modelHeightLog2;
    logic          modelClampS;
    logic          modelClampT;
    sampleExpect_t expectQueue [$];
    int            dueQueue [$];
    sampleExpect_t compareExpect;
    int            compareDue;

    texSampler dut_i
    (
        .aclk(aclk), .resetn(resetn),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .texStreamTvalid(texStreamTvalid), .texStreamTready(texStreamTready),
        .texStreamTlast(texStreamTlast), .texStreamTdata(texStreamTdata),
        .sampleValid(sampleValid), .coord(coord),
        .quadValid(quadValid), .quad(quad), .frac(frac)
    );

    initial
    begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Failure reporting and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic abortRun();
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic checkQuad(input string name, input texelQuad_t got, input texelQuad_t exp);
        if (got !== exp)
        begin
            $display("FAIL time=%0t %s got %h expected %h", $time, name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkFrac(input string name, input texFrac_t got, input texFrac_t exp);
        if (got !== exp)
        begin
            $display("FAIL time=%0t %s got %h expected %h", $time, name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkReg(input string name, input regData_t got, input regData_t exp);
        if (got !== exp)
        begin
            $display("FAIL time=%0t %s got %h expected %h", $time, name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkResp(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp)
        begin
            $display("FAIL time=%0t %s got %b expected %b", $time, name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("FAIL time=%0t %s got %b expected %b", $time, name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkCount(input string name, input int got, input int exp);
        if (got != exp)
        begin
            $display("FAIL time=%0t %s got %0d expected %0d", $time, name, got, exp);
            abortRun();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Wraps each axis by modulo or clamps the +1 neighbour, then indexes row-major
    function automatic sampleExpect_t expectSample(input texCoord_t c);
        sampleExpect_t e;
        int            w;
        int            h;
        int            s0;
        int            s1;
        int            t0;
        int            t1;
        w  = 1 << modelWidthLog2;
        h  = 1 << modelHeightLog2;
        s0 = int'(c.sInt) % w;
        t0 = int'(c.tInt) % h;
        if (modelClampS)
            s1 = (s0 + 1 >= w) ? w - 1 : s0 + 1;
        else
            s1 = (s0 + 1) % w;
        if (modelClampT)
            t1 = (t0 + 1 >= h) ? h - 1 : t0 + 1;
        else
            t1 = (t0 + 1) % h;
        e.quad.texel00 = texModel[t0 * w + s0];
        e.quad.texel01 = texModel[t0 * w + s1];
        e.quad.texel10 = texModel[t1 * w + s0];
        e.quad.texel11 = texModel[t1 * w + s1];
        e.frac.fracS   = c.sFrac;
        e.frac.fracT   = c.tFrac;
        return e;
    endfunction

    function automatic texCoord_t makeCoord(input coordInt_t s, input coordInt_t t);
        texCoord_t c;
        c.sInt  = s;
        c.tInt  = t;
        c.sFrac = $random(seed);
        c.tFrac = $random(seed);
        return c;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Drivers that change every input on the falling edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic axiWrite(input regAddr_t addr, input regData_t data,
                            output logic [1:0] resp);
        @(negedge aclk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        // Both readies are sampled on the rising edge that takes the pair
        @(posedge aclk);
        checkFlag("awready", awready, 1'b1);
        checkFlag("wready", wready, 1'b1);
        do
            @(negedge aclk);
        while (!bvalid);
        // No new pair is taken while the response waits
        checkFlag("awready", awready, 1'b0);
        checkFlag("wready", wready, 1'b0);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        resp    = bresp;
        bready  = 1'b1;
        @(negedge aclk);
        bready  = 1'b0;
    endtask

    task automatic axiRead(input regAddr_t addr, output regData_t data,
                           output logic [1:0] resp);
        @(negedge aclk);
        araddr  = addr;
        arvalid = 1'b1;
        @(posedge aclk);
        checkFlag("arready", arready, 1'b1);
        do
            @(negedge aclk);
        while (!rvalid);
        // The address channel stays closed while read data is pending
        checkFlag("arready", arready, 1'b0);
        arvalid = 1'b0;
        data    = rdata;
        resp    = rresp;
        rready  = 1'b1;
        @(negedge aclk);
        rready  = 1'b0;
    endtask

    task automatic writeAndCheck(input regAddr_t addr, input regData_t data,
                                 input logic [1:0] expResp);
        logic [1:0] resp;
        axiWrite(addr, data, resp);
        checkResp("bresp", resp, expResp);
    endtask

    task automatic readAndCheck(input regAddr_t addr, input regData_t expData,
                                input logic [1:0] expResp);
        regData_t   data;
        logic [1:0] resp;
        axiRead(addr, data, resp);
        checkReg("rdata", data, expData);
        checkResp("rresp", resp, expResp);
    endtask

    // The model follows the wrap register once the write has been answered
    task automatic setWrap(input logic clampS, input logic clampT);
        writeAndCheck(`REG_WRAP_MODE, {30'd0, clampT, clampS}, 2'b00);
        modelClampS = clampS;
        modelClampT = clampT;
    endtask

    task automatic uploadTexture(input int beatCount);
        int i;
        for (i = 0; i < beatCount; i++)
        begin
            @(negedge aclk);
            checkFlag("texStreamTready", texStreamTready, 1'b1);
            texStreamTvalid = 1'b1;
            texStreamTdata  = {texModel[2 * i + 1], texModel[2 * i]};
            texStreamTlast  = (i == beatCount - 1);
        end
        @(negedge aclk);
        texStreamTvalid = 1'b0;
        texStreamTlast  = 1'b0;
    endtask

    task automatic driveSample(input texCoord_t c);
        @(negedge aclk);
        sampleValid = 1'b1;
        coord       = c;
        expectQueue.push_back(expectSample(c));
        // Taken on the next rising edge and answered after the edge that follows
        dueQueue.push_back(cycleCount + 2);
        requestCount++;
    endtask

    task automatic idleCycle();
        @(negedge aclk);
        sampleValid = 1'b0;
    endtask

    // Every result is due two cycles after its request
    task automatic drainResults();
        repeat (5) idleCycle();
        if (expectQueue.size() != 0)
        begin
            $display("quadValid never came for %0d outstanding requests at time %0t",
                     expectQueue.size(), $time);
            abortRun();
        end
    endtask

    // Last column and row, and integer parts well beyond the texture size
    task automatic sampleEdges();
        driveSample(makeCoord(8'd15, 8'd15));
        driveSample(makeCoord(8'd15, 8'd6));
        driveSample(makeCoord(8'd3, 8'd15));
        driveSample(makeCoord(8'd200, 8'd77));
        driveSample(makeCoord(8'd255, 8'd255));
        driveSample(makeCoord(8'd31, 8'd16));
        repeat (16)
        begin
            driveSample(makeCoord($random(seed), $random(seed)));
            idleCycle();
        end
        drainResults();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Compare process and timeout
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge aclk)
    begin
        if (resetn && quadValid)
        begin
            if (expectQueue.size() == 0)
            begin
                $display("quadValid came with no request outstanding at time %0t", $time);
                abortRun();
            end
            else
            begin
                compareExpect = expectQueue.pop_front();
                compareDue    = dueQueue.pop_front();
                checkCount("quadValid cycle", cycleCount, compareDue);
                checkQuad("quad", quad, compareExpect.quad);
                checkFrac("frac", frac, compareExpect.frac);
                resultCount++;
            end
        end
    end

    always @(posedge aclk)
    begin
        cycleCount++;
        if (cycleCount == CYCLE_LIMIT)
        begin
            $display("Timeout after %0d cycles, the run did not finish", cycleCount);
            abortRun();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        int i;
        int gap;
        resetn          = 1'b0;
        awaddr          = '0;
        awvalid         = 1'b0;
        wdata           = '0;
        wvalid          = 1'b0;
        bready          = 1'b0;
        araddr          = '0;
        arvalid         = 1'b0;
        rready          = 1'b0;
        texStreamTvalid = 1'b0;
        texStreamTlast  = 1'b0;
        texStreamTdata  = '0;
        sampleValid     = 1'b0;
        coord           = '0;
        for (i = 0; i < 4096; i++)
            texModel[i] = $random(seed);

        repeat (5) @(posedge aclk);
        @(negedge aclk);
        resetn = 1'b1;

        // Reset state of every handshake and of the configuration
        @(negedge aclk);
        checkFlag("texStreamTready", texStreamTready, 1'b1);
        checkFlag("quadValid", quadValid, 1'b0);
        checkFlag("awready", awready, 1'b0);
        checkFlag("wready", wready, 1'b0);
        checkFlag("bvalid", bvalid, 1'b0);
        checkFlag("arready", arready, 1'b1);
        checkFlag("rvalid", rvalid, 1'b0);
        readAndCheck(`REG_TEX_SIZE, 32'h66, 2'b00);
        readAndCheck(`REG_WRAP_MODE, 32'h0, 2'b00);

        // Field read-back, saturation and the unknown offset
        writeAndCheck(`REG_TEX_SIZE, 32'h23, 2'b00);
        readAndCheck(`REG_TEX_SIZE, 32'h23, 2'b00);
        writeAndCheck(`REG_WRAP_MODE, 32'h3, 2'b00);
        readAndCheck(`REG_WRAP_MODE, 32'h3, 2'b00);
        writeAndCheck(`REG_TEX_SIZE, 32'h77, 2'b00);
        readAndCheck(`REG_TEX_SIZE, 32'h66, 2'b00);
        // This data would change both registers if the offset were decoded
        writeAndCheck(4'h8, 32'h0000_0011, 2'b10);
        readAndCheck(4'h8, 32'h0, 2'b10);
        readAndCheck(`REG_TEX_SIZE, 32'h66, 2'b00);
        readAndCheck(`REG_WRAP_MODE, 32'h3, 2'b00);

        // 16x16 texture in repeat mode
        writeAndCheck(`REG_TEX_SIZE, (TEX_LOG2 << 4) | TEX_LOG2, 2'b00);
        modelWidthLog2  = TEX_LOG2;
        modelHeightLog2 = TEX_LOG2;
        setWrap(1'b0, 1'b0);
        uploadTexture(BEAT_COUNT);

        // Interior coordinates
        repeat (64)
        begin
            driveSample(makeCoord($unsigned($random(seed)) % 16, $unsigned($random(seed)) % 16));
            idleCycle();
        end
        drainResults();

        // Repeat wrap, then clamp on both axes and on one axis at a time
        sampleEdges();
        setWrap(1'b1, 1'b1);
        sampleEdges();
        setWrap(1'b1, 1'b0);
        sampleEdges();
        setWrap(1'b0, 1'b1);
        sampleEdges();

        // Back-to-back requests with random gaps keep two results in flight
        setWrap(1'b0, 1'b0);
        repeat (150)
        begin
            driveSample($random(seed));
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) idleCycle();
        end
        drainResults();

        if (resultCount != requestCount)
        begin
            $display("FAIL time=%0t resultCount got %0d expected %0d",
                     $time, resultCount, requestCount);
            abortRun();
        end
        else
        begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

// File: texSampler.f
+incdir+rtl
rtl/texSamplerPkg.sv
rtl/texSamplerRegs.sv
rtl/texelAddressGen.sv
rtl/texelBankRam.sv
rtl/texelQuadBuffer.sv
rtl/texSampler.sv
tests/texSamplerTb.sv
